// File: clkmon_pkg.sv
package clkmon_pkg;

   // bus and data widths
   localparam int SAMPLE_W = 12;
   localparam int STRB_W   = 4;

   typedef logic [7:0]          addr_t;   // register byte address
   typedef logic [31:0]         data_t;   // axi data word
   typedef logic [SAMPLE_W-1:0] sample_t; // adc sample
   typedef logic [31:0]         freq_t;   // edges per gate window

   // what the two leds show
   typedef enum logic [1:0] {
      LED_STATE     = 2'd0, // armed / trigger_seen
      LED_HEART     = 2'd1, // heartbeat / external clock
      LED_FLASH     = 2'd2, // flash pattern on both
      LED_STATE_ALT = 2'd3  // same as LED_STATE
   } led_sel_t;

   // register map
   localparam addr_t ADDR_CTRL       = 8'h00;
   localparam addr_t ADDR_TRIG_LEVEL = 8'h04;
   localparam addr_t ADDR_EXT_LIMIT  = 8'h08;
   localparam addr_t ADDR_EXT_FREQ   = 8'h0C; // read only
   localparam addr_t ADDR_STATUS     = 8'h10; // read only

   // CTRL fields
   localparam int CTRL_ARM     = 0;
   localparam int CTRL_LED_LO  = 1;
   localparam int CTRL_LED_HI  = 2;
   localparam int CTRL_MON_DIS = 3;

   // STATUS bits
   localparam int STAT_ARMED     = 0;
   localparam int STAT_CHANGE    = 1;
   localparam int STAT_TRIGGERED = 2;

   localparam logic [1:0] RESP_OKAY = 2'b00;

endpackage

// File: clkmon_if.sv
// configuration from the register block to the functional blocks
interface cfg_if;
   clkmon_pkg::led_sel_t led_select;
   logic                 monitor_disable;
   clkmon_pkg::freq_t    ext_limit;
   clkmon_pkg::sample_t  trig_level;
   logic                 arm;

   modport master (
      output led_select,
      output monitor_disable,
      output ext_limit,
      output trig_level,
      output arm
   );

   modport reader (
      input led_select,
      input monitor_disable,
      input ext_limit,
      input trig_level,
      input arm
   );
endinterface

// measurement results, each field has exactly one driver
interface meas_if;
   clkmon_pkg::freq_t ext_freq;
   logic              ext_change;
   logic              armed;
   logic              trigger_seen;
   clkmon_pkg::data_t status;

   modport freq (output ext_freq, output ext_change);

   modport trig (output armed, output trigger_seen);

   modport ind (
      input  armed,
      input  ext_change,
      input  trigger_seen,
      output status
   );

   modport regs (input ext_freq, input status);
endinterface

// File: axil_regs.sv
module axil_regs (
   input  logic                                clk_usb,
   input  logic                                reset,

   // write address / data / response
   input  clkmon_pkg::addr_t                   s_awaddr_i,
   input  logic                                s_awvalid_i,
   output logic                                s_awready_o,
   input  clkmon_pkg::data_t                   s_wdata_i,
   input  logic [clkmon_pkg::STRB_W-1:0]       s_wstrb_i,
   input  logic                                s_wvalid_i,
   output logic                                s_wready_o,
   output logic [1:0]                          s_bresp_o,
   output logic                                s_bvalid_o,
   input  logic                                s_bready_i,

   // read address / data
   input  clkmon_pkg::addr_t                   s_araddr_i,
   input  logic                                s_arvalid_i,
   output logic                                s_arready_o,
   output clkmon_pkg::data_t                   s_rdata_o,
   output logic [1:0]                          s_rresp_o,
   output logic                                s_rvalid_o,
   input  logic                                s_rready_i,

   cfg_if.master                               cfg,
   meas_if.regs                                meas
);

   logic                aw_ready_q;
   logic                b_valid_q;
   logic                ar_ready_q;
   logic                r_valid_q;
   clkmon_pkg::data_t   r_data_q;
   clkmon_pkg::data_t   rd_word;
   logic                wr_en;
   logic [3:0]          ctrl_q;
   clkmon_pkg::sample_t level_q;
   clkmon_pkg::freq_t   limit_q;

   // merge write data into the old value under the byte strobes
   function automatic clkmon_pkg::data_t apply_strb(
      input clkmon_pkg::data_t               old_val,
      input clkmon_pkg::data_t               wd,
      input logic [clkmon_pkg::STRB_W-1:0]   strb
   );
      clkmon_pkg::data_t res;
      res = old_val;
      for (int i = 0; i < clkmon_pkg::STRB_W; i++) begin
         if (strb[i])
            res[8*i +: 8] = wd[8*i +: 8];
      end
      return res;
   endfunction

   assign wr_en = aw_ready_q & s_awvalid_i & s_wvalid_i;

   // write channel, one transaction at a time
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         aw_ready_q <= 1'b0;
         b_valid_q  <= 1'b0;
      end else begin
         aw_ready_q <= s_awvalid_i & s_wvalid_i & ~aw_ready_q & ~b_valid_q;
         if (aw_ready_q)
            b_valid_q <= 1'b1;
         else if (s_bready_i)
            b_valid_q <= 1'b0;
      end
   end

   // control registers, visible the cycle after awready
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         ctrl_q  <= '0;
         level_q <= '0;
         limit_q <= '0;
      end else if (wr_en) begin
         case (s_awaddr_i)
            clkmon_pkg::ADDR_CTRL:
               ctrl_q <= 4'(apply_strb(clkmon_pkg::data_t'(ctrl_q), s_wdata_i, s_wstrb_i));
            clkmon_pkg::ADDR_TRIG_LEVEL:
               level_q <= clkmon_pkg::sample_t'(
                  apply_strb(clkmon_pkg::data_t'(level_q), s_wdata_i, s_wstrb_i));
            clkmon_pkg::ADDR_EXT_LIMIT:
               limit_q <= apply_strb(limit_q, s_wdata_i, s_wstrb_i);
            default: ; // read-only or unmapped, dropped
         endcase
      end
   end

   // read mux
   always_comb begin
      case (s_araddr_i)
         clkmon_pkg::ADDR_CTRL:       rd_word = clkmon_pkg::data_t'(ctrl_q);
         clkmon_pkg::ADDR_TRIG_LEVEL: rd_word = clkmon_pkg::data_t'(level_q);
         clkmon_pkg::ADDR_EXT_LIMIT:  rd_word = limit_q;
         clkmon_pkg::ADDR_EXT_FREQ:   rd_word = meas.ext_freq;
         clkmon_pkg::ADDR_STATUS:     rd_word = meas.status;
         default:                     rd_word = '0;
      endcase
   end

   // read channel
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         ar_ready_q <= 1'b0;
         r_valid_q  <= 1'b0;
      end else begin
         ar_ready_q <= s_arvalid_i & ~r_valid_q & ~ar_ready_q;
         if (ar_ready_q)
            r_valid_q <= 1'b1;
         else if (s_rready_i)
            r_valid_q <= 1'b0;
      end
   end

   always_ff @(posedge clk_usb) begin
      if (ar_ready_q)
         r_data_q <= rd_word; // held until rready
   end

   assign s_awready_o = aw_ready_q;
   assign s_wready_o  = aw_ready_q;
   assign s_bvalid_o  = b_valid_q;
   assign s_bresp_o   = clkmon_pkg::RESP_OKAY;
   assign s_arready_o = ar_ready_q;
   assign s_rvalid_o  = r_valid_q;
   assign s_rdata_o   = r_data_q;
   assign s_rresp_o   = clkmon_pkg::RESP_OKAY;

   assign cfg.arm             = ctrl_q[clkmon_pkg::CTRL_ARM];
   assign cfg.led_select      =
      clkmon_pkg::led_sel_t'(ctrl_q[clkmon_pkg::CTRL_LED_HI:clkmon_pkg::CTRL_LED_LO]);
   assign cfg.monitor_disable = ctrl_q[clkmon_pkg::CTRL_MON_DIS];
   assign cfg.trig_level      = level_q;
   assign cfg.ext_limit       = limit_q;

endmodule

// File: freq_monitor.sv
module freq_monitor #(
   parameter int GATE_BITS = 10
) (
   input  logic   clk_usb,
   input  logic   reset,
   input  logic   ext_clk_i,
   cfg_if.reader  cfg,
   meas_if.freq   meas,
   output logic   ext_sync_o
);

   logic [GATE_BITS-1:0] gate_cnt;
   logic                 gate_end;
   logic [1:0]           sync_q;     // two-flop synchronizer
   logic                 ext_d;
   logic                 ext_rise;
   clkmon_pkg::freq_t    edge_cnt;
   clkmon_pkg::freq_t    window_cnt; // count including the last cycle
   clkmon_pkg::freq_t    freq_q;
   clkmon_pkg::freq_t    diff;
   logic                 change_q;

   assign gate_end   = &gate_cnt; // last cycle of the window
   assign ext_rise   = sync_q[1] & ~ext_d;
   assign window_cnt = edge_cnt + clkmon_pkg::freq_t'(ext_rise);

   // absolute difference to the previous window
   assign diff = (window_cnt > freq_q) ? window_cnt - freq_q : freq_q - window_cnt;

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         gate_cnt <= '0;
         sync_q   <= '0;
         ext_d    <= 1'b0;
      end else begin
         gate_cnt <= gate_cnt + 1'b1; // free running, wraps every window
         sync_q   <= {sync_q[0], ext_clk_i};
         ext_d    <= sync_q[1];
      end
   end

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         edge_cnt <= '0;
         freq_q   <= '0;
      end else if (gate_end) begin
         freq_q   <= window_cnt;
         edge_cnt <= '0;
      end else begin
         edge_cnt <= window_cnt;
      end
   end

   // sticky change flag, only a disable clears it
   always_ff @(posedge clk_usb) begin
      if (reset)
         change_q <= 1'b0;
      else if (cfg.monitor_disable)
         change_q <= 1'b0;
      else if (gate_end && (freq_q != '0) && (diff > cfg.ext_limit))
         change_q <= 1'b1;
   end

   assign meas.ext_freq   = freq_q;
   assign meas.ext_change = change_q;
   assign ext_sync_o      = sync_q[1];

endmodule

// File: level_trigger.sv
module level_trigger (
   input  logic                clk_usb,
   input  logic                reset,
   input  clkmon_pkg::sample_t adc_data_i,
   input  logic                adc_valid_i,
   cfg_if.reader               cfg,
   meas_if.trig                meas,
   output logic                trigger_adc_o
);

   logic arm_d;
   logic arm_rise;
   logic above;   // level msb picks the direction
   logic hit;
   logic armed_q;
   logic seen_q;
   logic trig_q;

   assign arm_rise = cfg.arm & ~arm_d;
   assign above    = cfg.trig_level[clkmon_pkg::SAMPLE_W-1];
   assign hit      = armed_q & adc_valid_i &
                     (above ? (adc_data_i > cfg.trig_level) : (adc_data_i < cfg.trig_level));

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         arm_d   <= 1'b0;
         armed_q <= 1'b0;
         seen_q  <= 1'b0;
         trig_q  <= 1'b0;
      end else begin
         arm_d  <= cfg.arm;
         trig_q <= hit; // single pulse, armed drops with it

         if (arm_rise)
            armed_q <= 1'b1;
         else if (hit)
            armed_q <= 1'b0;

         if (arm_rise)
            seen_q <= 1'b0;
         else if (hit)
            seen_q <= 1'b1;
      end
   end

   assign meas.armed        = armed_q;
   assign meas.trigger_seen = seen_q;
   assign trigger_adc_o     = trig_q;

endmodule

// File: status_indicators.sv
module status_indicators #(
   parameter int HEART_BITS = 24
) (
   input  logic   clk_usb,
   input  logic   reset,
   input  logic   ext_sync_i,
   cfg_if.reader  cfg,
   meas_if.ind    meas,
   output logic   led_a_o,
   output logic   led_b_o
);

   logic [HEART_BITS-1:0] heart_cnt;
   logic                  flash_q;
   clkmon_pkg::data_t     status_w;

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         heart_cnt <= '0;
         flash_q   <= 1'b0;
      end else begin
         heart_cnt <= heart_cnt + 1'b1;
         // blinks during the upper half of the heartbeat period
         if (heart_cnt[HEART_BITS-1])
            flash_q <= ~heart_cnt[HEART_BITS-2];
      end
   end

   // led mux, a flagged clock change wins over the selection
   always_comb begin
      if (meas.ext_change) begin
         led_a_o = flash_q;
         led_b_o = flash_q;
      end else begin
         case (cfg.led_select)
            clkmon_pkg::LED_HEART: begin
               led_a_o = heart_cnt[HEART_BITS-1];
               led_b_o = ext_sync_i;
            end
            clkmon_pkg::LED_FLASH: begin
               led_a_o = flash_q;
               led_b_o = flash_q;
            end
            clkmon_pkg::LED_STATE, clkmon_pkg::LED_STATE_ALT: begin
               led_a_o = meas.armed;
               led_b_o = meas.trigger_seen;
            end
            default: begin
               led_a_o = meas.armed;
               led_b_o = meas.trigger_seen;
            end
         endcase
      end
   end

   always_comb begin
      status_w                             = '0;
      status_w[clkmon_pkg::STAT_ARMED]     = meas.armed;
      status_w[clkmon_pkg::STAT_CHANGE]    = meas.ext_change;
      status_w[clkmon_pkg::STAT_TRIGGERED] = meas.trigger_seen;
   end

   assign meas.status = status_w;

endmodule

// File: clkmon_top.sv
module clkmon_top #(
   parameter int GATE_BITS  = 10,
   parameter int HEART_BITS = 24
) (
   input  logic                          clk_usb,
   input  logic                          reset,

   // axi4-lite slave
   input  clkmon_pkg::addr_t             s_awaddr_i,
   input  logic                          s_awvalid_i,
   output logic                          s_awready_o,
   input  clkmon_pkg::data_t             s_wdata_i,
   input  logic [clkmon_pkg::STRB_W-1:0] s_wstrb_i,
   input  logic                          s_wvalid_i,
   output logic                          s_wready_o,
   output logic [1:0]                    s_bresp_o,
   output logic                          s_bvalid_o,
   input  logic                          s_bready_i,
   input  clkmon_pkg::addr_t             s_araddr_i,
   input  logic                          s_arvalid_i,
   output logic                          s_arready_o,
   output clkmon_pkg::data_t             s_rdata_o,
   output logic [1:0]                    s_rresp_o,
   output logic                          s_rvalid_o,
   input  logic                          s_rready_i,

   input  logic                          ext_clk_i,   // target clock, sampled in clk_usb
   input  clkmon_pkg::sample_t           adc_data_i,
   input  logic                          adc_valid_i,
   output logic                          trigger_adc_o,
   output logic                          led_a_o,
   output logic                          led_b_o
);

   logic ext_sync;

   cfg_if  cfg_bus ();
   meas_if meas_bus ();

   axil_regs u_axil_regs (
      .clk_usb     (clk_usb),
      .reset       (reset),
      .s_awaddr_i  (s_awaddr_i),
      .s_awvalid_i (s_awvalid_i),
      .s_awready_o (s_awready_o),
      .s_wdata_i   (s_wdata_i),
      .s_wstrb_i   (s_wstrb_i),
      .s_wvalid_i  (s_wvalid_i),
      .s_wready_o  (s_wready_o),
      .s_bresp_o   (s_bresp_o),
      .s_bvalid_o  (s_bvalid_o),
      .s_bready_i  (s_bready_i),
      .s_araddr_i  (s_araddr_i),
      .s_arvalid_i (s_arvalid_i),
      .s_arready_o (s_arready_o),
      .s_rdata_o   (s_rdata_o),
      .s_rresp_o   (s_rresp_o),
      .s_rvalid_o  (s_rvalid_o),
      .s_rready_i  (s_rready_i),
      .cfg         (cfg_bus.master),
      .meas        (meas_bus.regs)
   );

   freq_monitor #(
      .GATE_BITS (GATE_BITS)
   ) u_freq_monitor (
      .clk_usb    (clk_usb),
      .reset      (reset),
      .ext_clk_i  (ext_clk_i),
      .cfg        (cfg_bus.reader),
      .meas       (meas_bus.freq),
      .ext_sync_o (ext_sync)
   );

   level_trigger u_level_trigger (
      .clk_usb       (clk_usb),
      .reset         (reset),
      .adc_data_i    (adc_data_i),
      .adc_valid_i   (adc_valid_i),
      .cfg           (cfg_bus.reader),
      .meas          (meas_bus.trig),
      .trigger_adc_o (trigger_adc_o)
   );

   status_indicators #(
      .HEART_BITS (HEART_BITS)
   ) u_status_indicators (
      .clk_usb    (clk_usb),
      .reset      (reset),
      .ext_sync_i (ext_sync),
      .cfg        (cfg_bus.reader),
      .meas       (meas_bus.ind),
      .led_a_o    (led_a_o),
      .led_b_o    (led_b_o)
   );

endmodule

// File: tb_clkmon.sv
module tb_clkmon;

   localparam int GATE_BITS  = 8;
   localparam int HEART_BITS = 6;
   localparam int WINDOW     = 1 << GATE_BITS;
   localparam int BUS_LIMIT  = 50;   // cycles allowed per handshake phase

   logic                                clk_usb;
   logic                                reset;
   clkmon_pkg::addr_t                   awaddr;
   logic                                awvalid;
   logic                                awready;
   clkmon_pkg::data_t                   wdata;
   logic [clkmon_pkg::STRB_W-1:0]       wstrb;
   logic                                wvalid;
   logic                                wready;
   logic [1:0]                          bresp;
   logic                                bvalid;
   logic                                bready;
   clkmon_pkg::addr_t                   araddr;
   logic                                arvalid;
   logic                                arready;
   clkmon_pkg::data_t                   rdata;
   logic [1:0]                          rresp;
   logic                                rvalid;
   logic                                rready;
   logic                                ext_clk;
   clkmon_pkg::sample_t                 adc_data;
   logic                                adc_valid;
   logic                                trigger_adc;
   logic                                led_a;
   logic                                led_b;

   int     half_period = 4;   // ext clock half period in clk_usb cycles
   int     cycle       = 0;
   integer seed        = 32'h92535006;

   clkmon_top #(
      .GATE_BITS  (GATE_BITS),
      .HEART_BITS (HEART_BITS)
   ) DUT (
      .clk_usb       (clk_usb),
      .reset         (reset),
      .s_awaddr_i    (awaddr),
      .s_awvalid_i   (awvalid),
      .s_awready_o   (awready),
      .s_wdata_i     (wdata),
      .s_wstrb_i     (wstrb),
      .s_wvalid_i    (wvalid),
      .s_wready_o    (wready),
      .s_bresp_o     (bresp),
      .s_bvalid_o    (bvalid),
      .s_bready_i    (bready),
      .s_araddr_i    (araddr),
      .s_arvalid_i   (arvalid),
      .s_arready_o   (arready),
      .s_rdata_o     (rdata),
      .s_rresp_o     (rresp),
      .s_rvalid_o    (rvalid),
      .s_rready_i    (rready),
      .ext_clk_i     (ext_clk),
      .adc_data_i    (adc_data),
      .adc_valid_i   (adc_valid),
      .trigger_adc_o (trigger_adc),
      .led_a_o       (led_a),
      .led_b_o       (led_b)
   );

   always #2 clk_usb = ~clk_usb;

   always @(posedge clk_usb) cycle <= cycle + 1;

   // target clock, half period picked up at each toggle
   always begin
      repeat (half_period) @(posedge clk_usb);
      ext_clk <= ~ext_clk;
   end

   task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                        input string msg);
      if (actual !== expected) begin
         $display("[FAIL] %0t %s: got 0x%0h, expected 0x%0h", $time, msg, actual, expected);
         $display("Verification failed");
         $fatal(1, "stopped at first mismatch");
      end
   endtask

   task automatic report_timeout(input string what);
      $display("timed out while waiting for %s", what);
      $display("Verification failed");
      $fatal(1, "wait timed out");
   endtask

   task automatic axi_write(input clkmon_pkg::addr_t addr, input clkmon_pkg::data_t data);
      int n;
      n = 0;
      @(posedge clk_usb);
      awaddr  <= addr;
      awvalid <= 1'b1;
      wdata   <= data;
      wstrb   <= '1;
      wvalid  <= 1'b1;
      do begin
         @(negedge clk_usb);
         n++;
         if (n > BUS_LIMIT)
            report_timeout("awready");
      end while (!awready);
      check(wready, 1'b1, "wready together with awready");
      @(posedge clk_usb);
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
      bready  <= 1'b1;
      n = 0;
      do begin
         @(negedge clk_usb);
         n++;
         if (n > BUS_LIMIT)
            report_timeout("bvalid");
      end while (!bvalid);
      check(bresp, clkmon_pkg::RESP_OKAY, "write response");
      @(posedge clk_usb);
      bready <= 1'b0;   // handshake completes on this edge
   endtask

   // hold keeps rready low for that many cycles once rvalid is up
   task automatic axi_read(input clkmon_pkg::addr_t addr, input int hold,
                           output clkmon_pkg::data_t data);
      int n;
      n = 0;
      @(posedge clk_usb);
      araddr  <= addr;
      arvalid <= 1'b1;
      rready  <= 1'b0;
      do begin
         @(negedge clk_usb);
         n++;
         if (n > BUS_LIMIT)
            report_timeout("arready");
      end while (!arready);
      @(posedge clk_usb);
      arvalid <= 1'b0;
      n = 0;
      do begin
         @(negedge clk_usb);
         n++;
         if (n > BUS_LIMIT)
            report_timeout("rvalid");
      end while (!rvalid);
      repeat (hold) begin
         @(negedge clk_usb);
         check(rvalid, 1'b1, "rvalid held under back-pressure");
      end
      @(posedge clk_usb);
      rready <= 1'b1;
      @(negedge clk_usb);
      check(rvalid, 1'b1, "rvalid at read handshake");
      check(rresp, clkmon_pkg::RESP_OKAY, "read response");
      data = rdata;
      @(posedge clk_usb);
      rready <= 1'b0;
   endtask

   // one adc cycle, the check sees the pulse caused two edges back
   task automatic step_adc(input clkmon_pkg::sample_t smp, input logic vld,
                           input logic exp_trig);
      @(posedge clk_usb);
      adc_data  <= smp;
      adc_valid <= vld;
      @(negedge clk_usb);
      check(trigger_adc, exp_trig, "trigger_adc_o");
   endtask

   task automatic check_state_leds(input logic exp_a, input logic exp_b);
      @(negedge clk_usb);
      check(led_a, exp_a, "led_a shows armed");
      check(led_b, exp_b, "led_b shows trigger_seen");
   endtask

   task automatic test_registers();
      clkmon_pkg::data_t rd;
      axi_read(clkmon_pkg::ADDR_STATUS, 0, rd);
      check(rd, 32'h0, "status after reset");
      axi_write(clkmon_pkg::ADDR_TRIG_LEVEL, 32'h0000_0ABC);
      axi_read(clkmon_pkg::ADDR_TRIG_LEVEL, 5, rd);
      check(rd, 32'h0000_0ABC, "trig level readback with stalled rready");
      axi_write(clkmon_pkg::ADDR_EXT_LIMIT, 32'h0001_2345);   // wide, keeps flag quiet
      axi_read(clkmon_pkg::ADDR_EXT_LIMIT, 0, rd);
      check(rd, 32'h0001_2345, "ext limit readback");
      axi_read(8'h14, 0, rd);
      check(rd, 32'h0, "unmapped address");
      axi_write(clkmon_pkg::ADDR_EXT_FREQ, 32'hFFFF_FFFF);
      axi_read(clkmon_pkg::ADDR_EXT_FREQ, 0, rd);
      check(rd, 32'h0, "ext freq ignores writes");   // first window not over yet
   endtask

   task automatic test_frequency();
      clkmon_pkg::data_t rd;
      int                expected;
      half_period = 4;
      expected    = WINDOW / (2 * half_period);
      repeat (2 * WINDOW + 40) @(posedge clk_usb);
      axi_read(clkmon_pkg::ADDR_EXT_FREQ, 0, rd);
      check((rd + 1 >= expected) && (rd <= expected + 1), 1'b1, "ext freq within one");
   endtask

   task automatic run_trigger(input clkmon_pkg::sample_t level);
      clkmon_pkg::data_t   rd;
      clkmon_pkg::sample_t smp;
      clkmon_pkg::sample_t hit;
      int unsigned         lv;
      int unsigned         r;
      lv = level;
      axi_write(clkmon_pkg::ADDR_TRIG_LEVEL, clkmon_pkg::data_t'(level));
      axi_write(clkmon_pkg::ADDR_CTRL, 32'h0);
      axi_write(clkmon_pkg::ADDR_CTRL, 32'h1);   // arm rising edge
      axi_read(clkmon_pkg::ADDR_STATUS, 0, rd);
      check(rd, 32'h1, "armed after arm edge");
      check_state_leds(1'b1, 1'b0);
      repeat (40) begin
         r = $random(seed);
         if (lv[11])
            smp = clkmon_pkg::sample_t'(r % (lv + 1));          // at or under the level
         else
            smp = clkmon_pkg::sample_t'(lv + r % (4096 - lv)); // at or over the level
         step_adc(smp, 1'b1, 1'b0);
      end
      r = $random(seed);
      if (lv[11])
         hit = clkmon_pkg::sample_t'(lv + 1 + r % (4095 - lv));
      else
         hit = clkmon_pkg::sample_t'(r % lv);
      step_adc(hit, 1'b0, 1'b0);   // not valid, ignored
      step_adc(hit, 1'b1, 1'b0);
      step_adc('0, 1'b0, 1'b1);
      step_adc('0, 1'b0, 1'b0);
      axi_read(clkmon_pkg::ADDR_STATUS, 0, rd);
      check(rd, 32'h4, "disarmed with trigger seen");
      check_state_leds(1'b0, 1'b1);
      repeat (10)
         step_adc(hit, 1'b1, 1'b0);   // one shot per arm
      step_adc('0, 1'b0, 1'b0);
      step_adc('0, 1'b0, 1'b0);
   endtask

   task automatic test_heart_led();
      logic first;
      int   n;
      axi_write(clkmon_pkg::ADDR_CTRL, 32'h2);   // LED_HEART
      repeat (2) begin
         @(negedge clk_usb);
         first = led_a;
         n     = 0;
         do begin
            @(negedge clk_usb);
            n++;
            if (n > (1 << HEART_BITS))
               report_timeout("heartbeat led toggle");
         end while (led_a == first);
      end
   endtask

   task automatic test_change();
      clkmon_pkg::data_t rd;
      int                start;
      axi_write(clkmon_pkg::ADDR_CTRL, 32'h8);
      axi_write(clkmon_pkg::ADDR_EXT_LIMIT, 32'd2);
      axi_write(clkmon_pkg::ADDR_CTRL, 32'h0);
      repeat (2 * WINDOW) @(posedge clk_usb);   // steady windows compared at limit 2
      axi_read(clkmon_pkg::ADDR_STATUS, 0, rd);
      check(rd[clkmon_pkg::STAT_CHANGE], 1'b0, "no change at steady frequency");
      half_period = 2;
      start       = cycle;
      do begin
         axi_read(clkmon_pkg::ADDR_STATUS, 0, rd);
         if (cycle - start > 3 * WINDOW)
            report_timeout("change flag");
      end while (!rd[clkmon_pkg::STAT_CHANGE]);
      // armed low and trigger_seen high would differ without the override
      repeat (3 * (1 << HEART_BITS)) begin
         @(negedge clk_usb);
         check(led_a, led_b, "both leds flash on change");
      end
      axi_write(clkmon_pkg::ADDR_CTRL, 32'h8);
      axi_read(clkmon_pkg::ADDR_STATUS, 0, rd);
      check(rd[clkmon_pkg::STAT_CHANGE], 1'b0, "disable clears change flag");

      // same step again, now inside a wide limit
      half_period = 4;
      axi_write(clkmon_pkg::ADDR_EXT_LIMIT, 32'd100);
      repeat (2 * WINDOW + 40) @(posedge clk_usb);
      axi_write(clkmon_pkg::ADDR_CTRL, 32'h0);
      half_period = 2;
      repeat (3 * WINDOW) @(posedge clk_usb);
      axi_read(clkmon_pkg::ADDR_STATUS, 0, rd);
      check(rd[clkmon_pkg::STAT_CHANGE], 1'b0, "step within limit ignored");
   endtask

   initial begin
      clk_usb   = 1'b0;
      reset     = 1'b1;
      awaddr    = '0;
      awvalid   = 1'b0;
      wdata     = '0;
      wstrb     = '0;
      wvalid    = 1'b0;
      bready    = 1'b0;
      araddr    = '0;
      arvalid   = 1'b0;
      rready    = 1'b0;
      ext_clk   = 1'b0;
      adc_data  = '0;
      adc_valid = 1'b0;
      repeat (3) @(posedge clk_usb);
      reset <= 1'b0;

      test_registers();
      test_frequency();
      run_trigger(12'h900);   // above
      run_trigger(12'h100);   // below
      test_heart_led();
      test_change();

      $display("Verification passed");
      $finish;
   end

endmodule

// File: tb.f
clkmon_pkg.sv
clkmon_if.sv
axil_regs.sv
freq_monitor.sv
level_trigger.sv
status_indicators.sv
clkmon_top.sv
tb_clkmon.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module tb_clkmon -f tb.f -o sim_clkmon &&
./obj_dir/sim_clkmon || exit 1
